//--- sources.f
+incdir+verilog
+incdir+tb
verilog/l2CachePkg.sv
verilog/requestCapture.sv
verilog/tagDirectory.sv
verilog/mesiController.sv
verilog/busResponder.sv
verilog/l2Cache.sv
tb/tbL2Cache.sv

//--- Makefile
# Verilator build and run for the L2 cache testbench

VERILATOR ?= verilator
TOP       ?= tbL2Cache
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= all tests passed

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh tb/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass message shows up on a line of its own
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/l2CacheModel.svh
// Reference model of the L2 directory
// Tags, MESI states, LRU ages and counters, updated as each request is driven
`ifndef L2CACHE_MODEL_SVH
`define L2CACHE_MODEL_SVH

// Outputs expected two cycles after a strobe
typedef struct packed {
  l2CachePkg::busReq_t    busReq;
  l2CachePkg::writeBack_t writeBack;
  l2CachePkg::snoopResp_t snoopResp;
  l2CachePkg::l1Resp_t    l1Resp;
} expect_t;

logic [`TAG_BITS-1:0] modelTag   [`SETS][`WAYS];
l2CachePkg::mesi_e    modelState [`SETS][`WAYS];
int                   modelAge   [`SETS][`WAYS];
int                   modelHits   = 0;
int                   modelMisses = 0;
int                   modelReads  = 0;
int                   modelWrites = 0;

// Empty directory, age of each way equals its number
task automatic modelClear();
  for (int s = 0; s < `SETS; s++) begin
    for (int w = 0; w < `WAYS; w++) begin
      modelState[s][w] = l2CachePkg::Invalid;
      modelAge[s][w]   = w;
    end
  end
endtask

task automatic lookupLine(input logic [`INDEX_BITS-1:0] index, input logic [`TAG_BITS-1:0] tag,
                          output logic found, output logic [`WAY_BITS-1:0] way);
  found = 1'b0;
  way   = '0;
  for (int w = 0; w < `WAYS; w++) begin
    if (modelState[index][w] != l2CachePkg::Invalid && modelTag[index][w] == tag) begin
      found = 1'b1;
      way   = `WAY_BITS'(w);
    end
  end
endtask

// First free way, otherwise the oldest one
task automatic pickVictim(input logic [`INDEX_BITS-1:0] index,
                          output logic [`WAY_BITS-1:0] way);
  logic found;
  found = 1'b0;
  way   = '0;
  for (int w = 0; w < `WAYS; w++) begin
    if (!found && modelState[index][w] == l2CachePkg::Invalid) begin
      found = 1'b1;
      way   = `WAY_BITS'(w);
    end
  end
  for (int w = 0; w < `WAYS; w++) begin
    if (!found && modelAge[index][w] == `WAYS - 1) begin
      way = `WAY_BITS'(w);
    end
  end
endtask

task automatic touchWay(input logic [`INDEX_BITS-1:0] index, input logic [`WAY_BITS-1:0] way);
  int oldAge;
  oldAge = modelAge[index][way];
  for (int w = 0; w < `WAYS; w++) begin
    if (modelAge[index][w] < oldAge) begin
      modelAge[index][w]++;
    end
  end
  modelAge[index][way] = 0;
endtask

//************************************************************
// Request rules
//************************************************************

task automatic modelSnoop(input l2CachePkg::snoopOp_e op, input logic [`ADDR_BITS-1:0] addr,
                          output expect_t expected);
  logic [`TAG_BITS-1:0]   tag;
  logic [`INDEX_BITS-1:0] index;
  logic                   found;
  logic [`WAY_BITS-1:0]   way;
  tag   = addr[`ADDR_BITS-1:`OFFSET_BITS+`INDEX_BITS];
  index = addr[`OFFSET_BITS+`INDEX_BITS-1:`OFFSET_BITS];
  lookupLine(index, tag, found, way);
  expected                  = '0;
  expected.snoopResp.valid  = 1'b1;
  expected.snoopResp.result = l2CachePkg::Miss;
  if (found) begin
    expected.snoopResp.result = l2CachePkg::Hit;
    // Invalidate carries no data, so a dirty hit still answers Hit
    if (modelState[index][way] == l2CachePkg::Modified &&
        op != l2CachePkg::SnoopInvalidate) begin
      expected.snoopResp.result = l2CachePkg::HitM;
      expected.writeBack.valid  = 1'b1;
      expected.writeBack.addr   = {tag, index, {`OFFSET_BITS{1'b0}}};
    end
    modelState[index][way] = (op == l2CachePkg::SnoopRead) ?
                             l2CachePkg::Shared : l2CachePkg::Invalid;
  end
endtask

task automatic modelL1(input l2CachePkg::l1Op_e op, input logic othersShared,
                       input logic [`ADDR_BITS-1:0] addr, output expect_t expected);
  logic [`TAG_BITS-1:0]   tag;
  logic [`INDEX_BITS-1:0] index;
  logic                   found;
  logic [`WAY_BITS-1:0]   way;
  logic                   isRead;
  tag      = addr[`ADDR_BITS-1:`OFFSET_BITS+`INDEX_BITS];
  index    = addr[`OFFSET_BITS+`INDEX_BITS-1:`OFFSET_BITS];
  isRead   = (op != l2CachePkg::DataWrite);
  expected = '0;
  if (op == l2CachePkg::Clear) begin
    modelClear();
  end else begin
    lookupLine(index, tag, found, way);
    expected.l1Resp.valid = 1'b1;
    expected.l1Resp.hit   = found;
    expected.l1Resp.addr  = addr;
    if (found) modelHits++;
    else modelMisses++;
    if (isRead) modelReads++;
    else modelWrites++;
    if (found && !isRead) begin
      if (modelState[index][way] == l2CachePkg::Shared) begin
        expected.busReq.valid = 1'b1;
        expected.busReq.op    = l2CachePkg::BusInvalidate;
        expected.busReq.addr  = addr;
      end
      modelState[index][way] = l2CachePkg::Modified;
    end else if (!found) begin
      pickVictim(index, way);
      // Dirty victim leaves before the fill
      if (modelState[index][way] == l2CachePkg::Modified) begin
        expected.writeBack.valid = 1'b1;
        expected.writeBack.addr  = {modelTag[index][way], index, {`OFFSET_BITS{1'b0}}};
      end
      expected.busReq.valid = 1'b1;
      expected.busReq.op    = isRead ? l2CachePkg::BusRead : l2CachePkg::BusRfo;
      expected.busReq.addr  = addr;
      modelTag[index][way]  = tag;
      if (!isRead) modelState[index][way] = l2CachePkg::Modified;
      else if (othersShared) modelState[index][way] = l2CachePkg::Shared;
      else modelState[index][way] = l2CachePkg::Exclusive;
    end
    touchWay(index, way);
  end
endtask

`endif

//--- tb/tbL2Cache.sv
// Testbench for the snooping MESI L2 cache directory
// Random L1 and snoop traffic on a few lines checked against a reference model
`include "l2Cache_defines.svh"

module tbL2Cache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REQUESTS   = 400;
  localparam int TIMEOUT_CYCLES = NUM_REQUESTS + 20;
  // Cycles from strobe to registered output
  localparam int PIPE_DEPTH     = 2;

  logic                   clk;
  logic                   rstN;
  l2CachePkg::l1Req_t     l1Req;
  l2CachePkg::snoopReq_t  snoopReq;
  l2CachePkg::busReq_t    busReq;
  l2CachePkg::writeBack_t writeBack;
  l2CachePkg::snoopResp_t snoopResp;
  l2CachePkg::l1Resp_t    l1Resp;
  logic [`COUNT_BITS-1:0] hitCount;
  logic [`COUNT_BITS-1:0] missCount;
  logic [`COUNT_BITS-1:0] readCount;
  logic [`COUNT_BITS-1:0] writeCount;

  `include "l2CacheModel.svh"

  logic [31:0]             lfsrState;
  expect_t                 expectQueue [$];
  int                      errorCount = 0;
  int                      checkCount = 0;
  int                      cycleCount = 0;
  // Small address pool so hits, evictions and snoop conflicts are common
  logic [`TAG_BITS-1:0]    tagPool   [6];
  logic [`INDEX_BITS-1:0]  indexPool [2];
  logic [`ADDR_BITS-1:0]   lastAddr;

  l2Cache i_l2Cache (
    .clk        (clk),
    .rstN       (rstN),
    .l1Req      (l1Req),
    .snoopReq   (snoopReq),
    .busReq     (busReq),
    .writeBack  (writeBack),
    .snoopResp  (snoopResp),
    .l1Resp     (l1Resp),
    .hitCount   (hitCount),
    .missCount  (missCount),
    .readCount  (readCount),
    .writeCount (writeCount)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //************************************************************
  // Random numbers
  //************************************************************

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsrBit();
    logic out;
    out       = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (out) lfsrState = lfsrState ^ 32'h80200003;
    return out;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsrBit()};
    end
    return value;
  endfunction

  function automatic logic [`ADDR_BITS-1:0] makeAddr();
    logic [2:0] tagSel;
    logic       indexSel;
    tagSel   = 3'(randBits(3) % 6);
    indexSel = randBits(1) != 0;
    return {tagPool[tagSel], indexPool[indexSel], `OFFSET_BITS'(randBits(`OFFSET_BITS))};
  endfunction

  //************************************************************
  // Stimulus
  //************************************************************

  // One cycle of traffic with the model updated in the order the DUT sees it
  task automatic driveRandomRequest();
    l2CachePkg::l1Req_t    nextL1;
    l2CachePkg::snoopReq_t nextSnoop;
    expect_t               expected;
    logic [4:0]            kind;
    logic [1:0]            opSel;
    nextL1    = '0;
    nextSnoop = '0;
    kind      = 5'(randBits(5));
    opSel     = 2'(randBits(2));
    if (randBits(1) == 0) lastAddr = makeAddr();
    nextL1.addr         = lastAddr;
    nextL1.othersShared = randBits(1) != 0;
    case (opSel)
      2'd0: nextL1.op = l2CachePkg::DataRead;
      2'd2: nextL1.op = l2CachePkg::InstrRead;
      default: nextL1.op = l2CachePkg::DataWrite;
    endcase
    nextSnoop.op   = l2CachePkg::snoopOp_e'(2'(randBits(2)));
    nextSnoop.addr = makeAddr();
    if (kind == 5'd0) begin
      nextL1.valid = 1'b1;
      nextL1.op    = l2CachePkg::Clear;
    end else if (kind <= 5'd4) begin
      // Kinds 2 to 4 collide and the snoop must win
      nextSnoop.valid = kind != 5'd1;
      nextL1.valid    = kind != 5'd1;
    end else if (kind <= 5'd11) begin
      nextSnoop.valid = 1'b1;
    end else begin
      nextL1.valid = 1'b1;
    end
    if (nextSnoop.valid) modelSnoop(nextSnoop.op, nextSnoop.addr, expected);
    else if (nextL1.valid) modelL1(nextL1.op, nextL1.othersShared, nextL1.addr, expected);
    else expected = '0;
    expectQueue.push_back(expected);
    l1Req    <= nextL1;
    snoopReq <= nextSnoop;
  endtask

  //************************************************************
  // Checking
  //************************************************************

  task automatic checkOutputs(input expect_t expected);
    checkCount++;
    if (busReq !== expected.busReq) begin
      errorCount++;
      $display("Fail at %0t: busReq expected %h got %h", $time, expected.busReq, busReq);
    end
    if (writeBack !== expected.writeBack) begin
      errorCount++;
      $display("Fail at %0t: writeBack expected %h got %h", $time, expected.writeBack, writeBack);
    end
    if (snoopResp !== expected.snoopResp) begin
      errorCount++;
      $display("Fail at %0t: snoopResp expected %h got %h", $time, expected.snoopResp, snoopResp);
    end
    if (l1Resp !== expected.l1Resp) begin
      errorCount++;
      $display("Fail at %0t: l1Resp expected %h got %h", $time, expected.l1Resp, l1Resp);
    end
  endtask

  task automatic checkCounters();
    if (hitCount !== `COUNT_BITS'(modelHits)) begin
      errorCount++;
      $display("Fail at %0t: hitCount expected %0d got %0d", $time, modelHits, hitCount);
    end
    if (missCount !== `COUNT_BITS'(modelMisses)) begin
      errorCount++;
      $display("Fail at %0t: missCount expected %0d got %0d", $time, modelMisses, missCount);
    end
    if (readCount !== `COUNT_BITS'(modelReads)) begin
      errorCount++;
      $display("Fail at %0t: readCount expected %0d got %0d", $time, modelReads, readCount);
    end
    if (writeCount !== `COUNT_BITS'(modelWrites)) begin
      errorCount++;
      $display("Fail at %0t: writeCount expected %0d got %0d", $time, modelWrites, writeCount);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (expectQueue.size() > PIPE_DEPTH) begin
      checkOutputs(expectQueue.pop_front());
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the request sequence never finished", cycleCount);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    lfsrState = 32'h839f;
    rstN      = 1'b0;
    l1Req     = '0;
    snoopReq  = '0;
    modelClear();
    for (int i = 0; i < 6; i++) begin
      tagPool[i] = `TAG_BITS'(randBits(`TAG_BITS));
    end
    indexPool[0] = `INDEX_BITS'(randBits(`INDEX_BITS));
    // Nonzero xor keeps the two sets apart
    indexPool[1] = indexPool[0] ^ `INDEX_BITS'(randBits(3) + 1);
    lastAddr     = makeAddr();
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    for (int n = 0; n < NUM_REQUESTS; n++) begin
      @(posedge clk);
      driveRandomRequest();
    end
    // Idle cycles drain the pipeline
    repeat (PIPE_DEPTH + 1) begin
      @(posedge clk);
      l1Req    <= '0;
      snoopReq <= '0;
      expectQueue.push_back('0);
    end
    // Second falling edge has no output check left to run
    repeat (2) @(negedge clk);
    checkCounters();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verilog/l2Cache.sv
// Snooping MESI L2 cache directory
// Capture stage, tag directory, MESI controller and output stage
`include "l2Cache_defines.svh"

module l2Cache (
  input  logic                   clk,
  input  logic                   rstN,
  input  l2CachePkg::l1Req_t     l1Req,
  input  l2CachePkg::snoopReq_t  snoopReq,
  output l2CachePkg::busReq_t    busReq,
  output l2CachePkg::writeBack_t writeBack,
  output l2CachePkg::snoopResp_t snoopResp,
  output l2CachePkg::l1Resp_t    l1Resp,
  output logic [`COUNT_BITS-1:0] hitCount,
  output logic [`COUNT_BITS-1:0] missCount,
  output logic [`COUNT_BITS-1:0] readCount,
  output logic [`COUNT_BITS-1:0] writeCount
);

  // Lookup stage request
  l2CachePkg::lookup_t    lookupReq;
  // Directory lookup result
  logic                   hit;
  logic [`WAY_BITS-1:0]   hitWay;
  logic [`WAY_BITS-1:0]   victimWay;
  l2CachePkg::mesi_e      hitState;
  l2CachePkg::mesi_e      victimState;
  logic [`TAG_BITS-1:0]   victimTag;
  l2CachePkg::dirUpdate_t dirUpdate;
  // Unregistered decisions
  l2CachePkg::busReq_t    busReqNext;
  l2CachePkg::writeBack_t writeBackNext;
  l2CachePkg::snoopResp_t snoopRespNext;
  l2CachePkg::l1Resp_t    l1RespNext;
  logic                   hitInc;
  logic                   missInc;
  logic                   readInc;
  logic                   writeInc;

  requestCapture i_requestCapture (
    .clk       (clk),
    .rstN      (rstN),
    .l1Req     (l1Req),
    .snoopReq  (snoopReq),
    .lookupReq (lookupReq)
  );

  tagDirectory i_tagDirectory (
    .clk         (clk),
    .rstN        (rstN),
    .lookupReq   (lookupReq),
    .dirUpdate   (dirUpdate),
    .hit         (hit),
    .hitWay      (hitWay),
    .hitState    (hitState),
    .victimWay   (victimWay),
    .victimState (victimState),
    .victimTag   (victimTag)
  );

  mesiController i_mesiController (
    .lookupReq     (lookupReq),
    .hit           (hit),
    .hitWay        (hitWay),
    .hitState      (hitState),
    .victimWay     (victimWay),
    .victimState   (victimState),
    .victimTag     (victimTag),
    .dirUpdate     (dirUpdate),
    .busReqNext    (busReqNext),
    .writeBackNext (writeBackNext),
    .snoopRespNext (snoopRespNext),
    .l1RespNext    (l1RespNext),
    .hitInc        (hitInc),
    .missInc       (missInc),
    .readInc       (readInc),
    .writeInc      (writeInc)
  );

  busResponder i_busResponder (
    .clk           (clk),
    .rstN          (rstN),
    .busReqNext    (busReqNext),
    .writeBackNext (writeBackNext),
    .snoopRespNext (snoopRespNext),
    .l1RespNext    (l1RespNext),
    .hitInc        (hitInc),
    .missInc       (missInc),
    .readInc       (readInc),
    .writeInc      (writeInc),
    .busReq        (busReq),
    .writeBack     (writeBack),
    .snoopResp     (snoopResp),
    .l1Resp        (l1Resp),
    .hitCount      (hitCount),
    .missCount     (missCount),
    .readCount     (readCount),
    .writeCount    (writeCount)
  );

endmodule

//--- verilog/busResponder.sv
// Output stage
// Registers the bus, write-back, snoop and L1 outputs and counts accesses
`include "l2Cache_defines.svh"

module busResponder (
  input  logic                    clk,
  input  logic                    rstN,
  input  l2CachePkg::busReq_t     busReqNext,
  input  l2CachePkg::writeBack_t  writeBackNext,
  input  l2CachePkg::snoopResp_t  snoopRespNext,
  input  l2CachePkg::l1Resp_t     l1RespNext,
  input  logic                    hitInc,
  input  logic                    missInc,
  input  logic                    readInc,
  input  logic                    writeInc,
  output l2CachePkg::busReq_t     busReq,
  output l2CachePkg::writeBack_t  writeBack,
  output l2CachePkg::snoopResp_t  snoopResp,
  output l2CachePkg::l1Resp_t     l1Resp,
  output logic [`COUNT_BITS-1:0]  hitCount,
  output logic [`COUNT_BITS-1:0]  missCount,
  output logic [`COUNT_BITS-1:0]  readCount,
  output logic [`COUNT_BITS-1:0]  writeCount
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busReq     <= '0;
      writeBack  <= '0;
      snoopResp  <= '0;
      l1Resp     <= '0;
      hitCount   <= '0;
      missCount  <= '0;
      readCount  <= '0;
      writeCount <= '0;
    end else begin
      // Decisions leave on the same edge as the directory write
      busReq    <= busReqNext;
      writeBack <= writeBackNext;
      snoopResp <= snoopRespNext;
      l1Resp    <= l1RespNext;

      // Free-running statistics, wrap at full scale
      if (hitInc) begin
        hitCount <= hitCount + `COUNT_BITS'(1);
      end
      if (missInc) begin
        missCount <= missCount + `COUNT_BITS'(1);
      end
      if (readInc) begin
        readCount <= readCount + `COUNT_BITS'(1);
      end
      if (writeInc) begin
        writeCount <= writeCount + `COUNT_BITS'(1);
      end
    end
  end

endmodule

//--- verilog/mesiController.sv
// MESI controller
// Decides the next state, bus action, snoop answer and L1 response
// for the request in the lookup stage
`include "l2Cache_defines.svh"

module mesiController (
  input  l2CachePkg::lookup_t    lookupReq,
  input  logic                   hit,
  input  logic [`WAY_BITS-1:0]   hitWay,
  input  l2CachePkg::mesi_e      hitState,
  input  logic [`WAY_BITS-1:0]   victimWay,
  input  l2CachePkg::mesi_e      victimState,
  input  logic [`TAG_BITS-1:0]   victimTag,
  output l2CachePkg::dirUpdate_t dirUpdate,
  output l2CachePkg::busReq_t    busReqNext,
  output l2CachePkg::writeBack_t writeBackNext,
  output l2CachePkg::snoopResp_t snoopRespNext,
  output l2CachePkg::l1Resp_t    l1RespNext,
  output logic                   hitInc,
  output logic                   missInc,
  output logic                   readInc,
  output logic                   writeInc
);

  // Line addresses with the byte select cleared
  logic [`ADDR_BITS-1:0] lineAddr;
  logic [`ADDR_BITS-1:0] victimAddr;
  // Data and instruction reads behave alike
  logic                  isRead;

  assign lineAddr   = {lookupReq.tag, lookupReq.index, {`OFFSET_BITS{1'b0}}};
  assign victimAddr = {victimTag, lookupReq.index, {`OFFSET_BITS{1'b0}}};
  assign isRead     = (lookupReq.l1Op == l2CachePkg::DataRead) ||
                      (lookupReq.l1Op == l2CachePkg::InstrRead);

  always_comb begin
    dirUpdate     = '0;
    busReqNext    = '0;
    writeBackNext = '0;
    snoopRespNext = '0;
    l1RespNext    = '0;
    hitInc        = 1'b0;
    missInc       = 1'b0;
    readInc       = 1'b0;
    writeInc      = 1'b0;

    //************************************************************
    // Snooped bus request
    //************************************************************
    if (lookupReq.valid && lookupReq.isSnoop) begin
      snoopRespNext.valid  = 1'b1;
      snoopRespNext.result = l2CachePkg::Miss;
      if (hit) begin
        // LRU is left alone on snoops
        dirUpdate.valid    = 1'b1;
        dirUpdate.way      = hitWay;
        dirUpdate.newState = (lookupReq.snoopOp == l2CachePkg::SnoopRead) ?
                             l2CachePkg::Shared : l2CachePkg::Invalid;
        snoopRespNext.result = l2CachePkg::Hit;
        // Dirty data goes back except on a plain invalidate
        if (hitState == l2CachePkg::Modified &&
            lookupReq.snoopOp != l2CachePkg::SnoopInvalidate) begin
          snoopRespNext.result = l2CachePkg::HitM;
          writeBackNext.valid  = 1'b1;
          writeBackNext.addr   = lineAddr;
        end
      end

    //************************************************************
    // L1 clear, read and write
    //************************************************************
    end else if (lookupReq.valid && lookupReq.l1Op == l2CachePkg::Clear) begin
      dirUpdate.clearAll = 1'b1;
    end else if (lookupReq.valid) begin
      l1RespNext.valid   = 1'b1;
      l1RespNext.hit     = hit;
      l1RespNext.addr    = lookupReq.addr;
      hitInc             = hit;
      missInc            = !hit;
      readInc            = isRead;
      writeInc           = !isRead;
      dirUpdate.valid    = 1'b1;
      dirUpdate.touchLru = 1'b1;
      dirUpdate.way      = hit ? hitWay : victimWay;
      if (hit) begin
        if (isRead) begin
          dirUpdate.newState = hitState;
        end else begin
          dirUpdate.newState = l2CachePkg::Modified;
          // Other copies must go before we own the line
          if (hitState == l2CachePkg::Shared) begin
            busReqNext.valid = 1'b1;
            busReqNext.op    = l2CachePkg::BusInvalidate;
            busReqNext.addr  = lookupReq.addr;
          end
        end
      end else begin
        // Miss fills the victim way
        dirUpdate.writeTag = 1'b1;
        busReqNext.valid   = 1'b1;
        busReqNext.op      = isRead ? l2CachePkg::BusRead : l2CachePkg::BusRfo;
        busReqNext.addr    = lookupReq.addr;
        if (victimState == l2CachePkg::Modified) begin
          writeBackNext.valid = 1'b1;
          writeBackNext.addr  = victimAddr;
        end
        if (!isRead) begin
          dirUpdate.newState = l2CachePkg::Modified;
        end else if (lookupReq.othersShared) begin
          dirUpdate.newState = l2CachePkg::Shared;
        end else begin
          dirUpdate.newState = l2CachePkg::Exclusive;
        end
      end
    end
  end

endmodule

//--- verilog/tagDirectory.sv
// Tag directory
// Tag, MESI and LRU age per way, hit and victim lookup for the held request
// and the state write from the controller
`include "l2Cache_defines.svh"

module tagDirectory (
  input  logic                   clk,
  input  logic                   rstN,
  input  l2CachePkg::lookup_t    lookupReq,
  input  l2CachePkg::dirUpdate_t dirUpdate,
  output logic                   hit,
  output logic [`WAY_BITS-1:0]   hitWay,
  output l2CachePkg::mesi_e      hitState,
  output logic [`WAY_BITS-1:0]   victimWay,
  output l2CachePkg::mesi_e      victimState,
  output logic [`TAG_BITS-1:0]   victimTag
);

  //************************************************************
  // Storage
  //************************************************************

  logic [`TAG_BITS-1:0] tagArray   [`SETS][`WAYS];
  l2CachePkg::mesi_e    stateArray [`SETS][`WAYS];
  logic [`AGE_BITS-1:0] ageArray   [`SETS][`WAYS];

  // Set an Invalid way was found in
  logic                 foundInvalid;
  // Age of the way being touched
  logic [`AGE_BITS-1:0] touchedAge;

  //************************************************************
  // Lookup
  //************************************************************

  // Hit needs a matching tag in a valid way
  always_comb begin
    hit      = 1'b0;
    hitWay   = '0;
    hitState = l2CachePkg::Invalid;
    for (int w = 0; w < `WAYS; w++) begin
      if (tagArray[lookupReq.index][w] == lookupReq.tag &&
          stateArray[lookupReq.index][w] != l2CachePkg::Invalid) begin
        hit      = 1'b1;
        hitWay   = `WAY_BITS'(w);
        hitState = stateArray[lookupReq.index][w];
      end
    end
  end

  // Victim is the lowest free way, else the oldest
  always_comb begin
    foundInvalid = 1'b0;
    victimWay    = '0;
    for (int w = 0; w < `WAYS; w++) begin
      if (!foundInvalid && stateArray[lookupReq.index][w] == l2CachePkg::Invalid) begin
        foundInvalid = 1'b1;
        victimWay    = `WAY_BITS'(w);
      end
    end
    if (!foundInvalid) begin
      for (int w = 0; w < `WAYS; w++) begin
        if (ageArray[lookupReq.index][w] == `AGE_BITS'(`WAYS-1)) begin
          victimWay = `WAY_BITS'(w);
        end
      end
    end
  end

  assign victimState = stateArray[lookupReq.index][victimWay];
  assign victimTag   = tagArray[lookupReq.index][victimWay];
  assign touchedAge  = ageArray[lookupReq.index][dirUpdate.way];

  //************************************************************
  // Update
  //************************************************************

  // Tags only load on a fill
  always_ff @(posedge clk) begin
    if (dirUpdate.valid && dirUpdate.writeTag) begin
      tagArray[lookupReq.index][dirUpdate.way] <= lookupReq.tag;
    end
  end

  // Reset and clear restore the same picture
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int s = 0; s < `SETS; s++) begin
        for (int w = 0; w < `WAYS; w++) begin
          stateArray[s][w] <= l2CachePkg::Invalid;
          ageArray[s][w]   <= `AGE_BITS'(w);
        end
      end
    end else if (dirUpdate.clearAll) begin
      for (int s = 0; s < `SETS; s++) begin
        for (int w = 0; w < `WAYS; w++) begin
          stateArray[s][w] <= l2CachePkg::Invalid;
          ageArray[s][w]   <= `AGE_BITS'(w);
        end
      end
    end else if (dirUpdate.valid) begin
      stateArray[lookupReq.index][dirUpdate.way] <= dirUpdate.newState;
      if (dirUpdate.touchLru) begin
        // Younger ways age by one, touched way becomes newest
        for (int w = 0; w < `WAYS; w++) begin
          if (ageArray[lookupReq.index][w] < touchedAge) begin
            ageArray[lookupReq.index][w] <= ageArray[lookupReq.index][w] + `AGE_BITS'(1);
          end
        end
        ageArray[lookupReq.index][dirUpdate.way] <= '0;
      end
    end
  end

endmodule

//--- verilog/requestCapture.sv
// Request capture stage
// Picks one request per cycle, snoop first, and holds it for the lookup
`include "l2Cache_defines.svh"

module requestCapture (
  input  logic                  clk,
  input  logic                  rstN,
  input  l2CachePkg::l1Req_t    l1Req,
  input  l2CachePkg::snoopReq_t snoopReq,
  output l2CachePkg::lookup_t   lookupReq
);

  // Request chosen this cycle
  l2CachePkg::lookup_t nextReq;
  // Held payload and its valid flag
  l2CachePkg::lookup_t heldReq;
  logic                heldValid;

  always_comb begin
    nextReq              = '0;
    nextReq.valid        = snoopReq.valid | l1Req.valid;
    nextReq.isSnoop      = snoopReq.valid;
    nextReq.l1Op         = l1Req.op;
    nextReq.snoopOp      = snoopReq.op;
    nextReq.othersShared = l1Req.othersShared;
    // Bus snoop wins, the L1 request of the same cycle is dropped
    nextReq.addr         = snoopReq.valid ? snoopReq.addr : l1Req.addr;
    // Split into tag and set index
    nextReq.tag   = nextReq.addr[`ADDR_BITS-1:`OFFSET_BITS+`INDEX_BITS];
    nextReq.index = nextReq.addr[`OFFSET_BITS+`INDEX_BITS-1:`OFFSET_BITS];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      heldValid <= 1'b0;
    end else begin
      // Idle cycle leaves the stage empty
      heldValid <= nextReq.valid;
    end
  end

  // Payload only loads when something arrives
  always_ff @(posedge clk) begin
    if (nextReq.valid) begin
      heldReq <= nextReq;
    end
  end

  always_comb begin
    lookupReq       = heldReq;
    lookupReq.valid = heldValid;
  end

endmodule

//--- verilog/l2CachePkg.sv
// L2 cache types
// MESI state, request opcodes, snoop results and the structs passed between blocks
`include "l2Cache_defines.svh"

package l2CachePkg;

  // Line coherence state
  typedef enum logic [1:0] {
    Modified,
    Exclusive,
    Shared,
    Invalid
  } mesi_e;

  // Requests from the L1 side
  typedef enum logic [1:0] {
    DataRead,
    DataWrite,
    InstrRead,
    Clear
  } l1Op_e;

  // Requests seen on the shared bus from other caches
  typedef enum logic [1:0] {
    SnoopRead,
    SnoopWrite,
    SnoopRfo,
    SnoopInvalidate
  } snoopOp_e;

  // Answer we drive on the snoop lines
  typedef enum logic [1:0] {
    Miss = 2'b00,
    Hit  = 2'b01,
    HitM = 2'b10
  } snoopResult_e;

  // Bus transactions we start
  typedef enum logic [1:0] {
    BusRead,
    BusRfo,
    BusInvalidate
  } busOp_e;

  // L1 request, othersShared is the snoop answer for our own fill
  typedef struct packed {
    logic                   valid;
    l1Op_e                  op;
    logic                   othersShared;
    logic [`ADDR_BITS-1:0]  addr;
  } l1Req_t;

  typedef struct packed {
    logic                   valid;
    snoopOp_e               op;
    logic [`ADDR_BITS-1:0]  addr;
  } snoopReq_t;

  // Request held in the lookup stage
  typedef struct packed {
    logic                   valid;
    logic                   isSnoop;
    l1Op_e                  l1Op;
    snoopOp_e               snoopOp;
    logic                   othersShared;
    logic [`TAG_BITS-1:0]   tag;
    logic [`INDEX_BITS-1:0] index;
    logic [`ADDR_BITS-1:0]  addr;
  } lookup_t;

  typedef struct packed {
    logic                   valid;
    busOp_e                 op;
    logic [`ADDR_BITS-1:0]  addr;
  } busReq_t;

  // Line address of a dirty line leaving this cache
  typedef struct packed {
    logic                   valid;
    logic [`ADDR_BITS-1:0]  addr;
  } writeBack_t;

  typedef struct packed {
    logic                   valid;
    snoopResult_e           result;
  } snoopResp_t;

  typedef struct packed {
    logic                   valid;
    logic                   hit;
    logic [`ADDR_BITS-1:0]  addr;
  } l1Resp_t;

  // Directory write for the set in lookup
  typedef struct packed {
    logic                   valid;
    logic [`WAY_BITS-1:0]   way;
    logic                   writeTag;
    mesi_e                  newState;
    logic                   touchLru;
    logic                   clearAll;
  } dirUpdate_t;

endpackage

//--- verilog/l2Cache_defines.svh
// L2 cache size macros
// Address split, directory geometry and statistics width
`ifndef L2CACHE_DEFINES_SVH
`define L2CACHE_DEFINES_SVH

//************************************************************
// Address layout
//************************************************************

// Full physical address width
`define ADDR_BITS 32

// Byte select within a 64-byte line
`define OFFSET_BITS 6

// Set index bits
`define INDEX_BITS 4

// Tag is whatever is left above index and offset
`define TAG_BITS 22

//************************************************************
// Directory geometry
//************************************************************

// Number of sets, two to the index width
`define SETS 16

// Associativity
`define WAYS 4

// Way number width
`define WAY_BITS 2

// LRU age per way, 0 is most recent
`define AGE_BITS 2

//************************************************************
// Statistics
//************************************************************

// Hit, miss, read and write counters
`define COUNT_BITS 32

`endif
